//--- rvs_macros.svh
`ifndef RVS_MACROS_SVH
`define RVS_MACROS_SVH

// data and address width
`define RVS_XLEN 64

// machine CSR addresses
`define RVS_CSR_MEPC    12'd833
`define RVS_CSR_MCAUSE  12'd834
`define RVS_CSR_MTVEC   12'd773
`define RVS_CSR_MSTATUS 12'd768

// id sent with every load and expected back on the response
`define RVS_LSU_ID 4'd2

// cycles from accept to done on the read bus
`define RVS_RD_LATENCY 3

// constant mixed into the memory contents rule
`define RVS_MEM_PATTERN 32'hA5C3_5A3C

// mcause value for an environment call from M-mode
`define RVS_ECALL_CAUSE 11

`endif

//--- rvs_pkg.sv
`include "rvs_macros.svh"

package rvs_pkg;

    typedef logic [`RVS_XLEN-1:0] xlen_t;
    typedef logic [`RVS_XLEN-1:0] addr_t;
    typedef logic [3:0]           txn_id_t;
    typedef logic [11:0]          csr_addr_t;

    // nonzero kind means a load is requested
    typedef enum logic [2:0] {
        LD_NONE  = 3'd0,
        LD_WORD  = 3'd1,
        LD_DWORD = 3'd2,
        LD_BYTE  = 3'd4,
        LD_HALF  = 3'd6
    } load_kind_t;

    typedef enum logic [1:0] {EXT_RAW, EXT_SIGN_W, EXT_ZERO_W, EXT_SIGN_H} ext_mode_t;

    typedef enum logic [1:0] {OP_NONE, OP_CSRRS, OP_CSRRW, OP_ECALL} stage_op_t;

    typedef enum logic [1:0] {S_IDLE, S_MEM, S_EN, S_FN} lsu_state_t;

    // read request, valid is a level
    typedef struct packed {
        addr_t   addr;
        txn_id_t id;
        logic    valid;
    } rd_req_t;

    // read response, done is a single-cycle pulse
    typedef struct packed {
        logic    done;
        txn_id_t id;
        xlen_t   data;
    } rd_rsp_t;

    typedef struct packed {
        xlen_t mepc;
        xlen_t mcause;
        xlen_t mtvec;
        xlen_t mstatus;
    } csr_file_t;

endpackage

//--- load_format.sv
`timescale 1ns/1ps

module load_format import rvs_pkg::*; (
    input  xlen_t      raw,
    input  logic [2:0] lane,
    input  load_kind_t kind,
    input  ext_mode_t  mode,
    output xlen_t      result
);

    xlen_t shifted;
    xlen_t kept;

    // move the addressed byte lane down to bit 0
    assign shifted = raw >> {lane, 3'b000};

    // keep only the bytes the load asked for
    always_comb begin
        case (kind)
            LD_BYTE:  kept = {56'd0, shifted[7:0]};
            LD_HALF:  kept = {48'd0, shifted[15:0]};
            LD_WORD:  kept = {32'd0, shifted[31:0]};
            LD_DWORD: kept = shifted;
            default:  kept = shifted;
        endcase
    end

    // extension per instruction class
    always_comb begin
        case (mode)
            EXT_RAW: begin
                result = kept;
            end
            EXT_SIGN_W: begin
                // lw and the *w arithmetic ops
                result = {{32{kept[31]}}, kept[31:0]};
            end
            EXT_ZERO_W: begin
                result = {32'd0, kept[31:0]};
            end
            EXT_SIGN_H: begin
                // lh
                result = {{48{kept[15]}}, kept[15:0]};
            end
            default: begin
                result = kept;
            end
        endcase
    end

endmodule

//--- csr_unit.sv
`timescale 1ns/1ps
`include "rvs_macros.svh"

module csr_unit import rvs_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  stage_op_t op,
    input  csr_addr_t csr_addr,
    input  xlen_t     src1,
    input  xlen_t     src2,
    output csr_file_t csrs
);

    xlen_t wdata;
    logic  wr_en;

    // csrrs sets bits from both sources, csrrw takes src1 as is
    assign wdata = (op == OP_CSRRS) ? (src1 | src2) : src1;
    assign wr_en = (op == OP_CSRRS) || (op == OP_CSRRW);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csrs <= '0;
        end else if (op == OP_ECALL) begin
            csrs.mepc       <= src1;
            csrs.mcause     <= xlen_t'(`RVS_ECALL_CAUSE);
            // MPIE takes MIE, then interrupts go off
            csrs.mstatus[7] <= csrs.mstatus[3];
            csrs.mstatus[3] <= 1'b0;
        end else if (wr_en) begin
            case (csr_addr)
                `RVS_CSR_MEPC: begin
                    csrs.mepc <= wdata;
                end
                `RVS_CSR_MCAUSE: begin
                    csrs.mcause <= wdata;
                end
                `RVS_CSR_MTVEC: begin
                    csrs.mtvec <= wdata;
                end
                `RVS_CSR_MSTATUS: begin
                    csrs.mstatus <= wdata;
                end
                default: begin
                    // unknown address, nothing written
                end
            endcase
        end
    end

    // trap cause must be visible one cycle after the ecall
    ecall_sets_cause: assert property (
        @(posedge clk) disable iff (!rst_n)
        (op == OP_ECALL) |=> (csrs.mcause == xlen_t'(`RVS_ECALL_CAUSE))
    ) else $error("mcause not set after ecall");

endmodule

//--- mem_stage.sv
`timescale 1ns/1ps
`include "rvs_macros.svh"

module mem_stage import rvs_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  load_kind_t load_kind,
    input  ext_mode_t  ext_mode,
    input  xlen_t      base,
    input  xlen_t      offset,
    input  stage_op_t  op,
    input  csr_addr_t  csr_addr,
    input  xlen_t      src1,
    input  xlen_t      src2,
    output rd_req_t    rd_req,
    input  logic       ar_hs,
    input  rd_rsp_t    rd_rsp,
    output logic       res_valid,
    output xlen_t      res_data,
    output logic       idle,
    output csr_file_t  csrs
);

    lsu_state_t state;
    lsu_state_t state_n;
    addr_t      addr_q;
    load_kind_t kind_q;
    ext_mode_t  mode_q;
    xlen_t      data_q;
    logic       rsp_match;

    // only our own id ends the wait
    assign rsp_match = rd_rsp.done && (rd_rsp.id == txn_id_t'(`RVS_LSU_ID));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_n;
        end
    end

    always_comb begin
        state_n = state;
        case (state)
            S_IDLE: begin
                if (load_kind != LD_NONE) begin
                    state_n = S_MEM;
                end
            end
            S_MEM: begin
                if (ar_hs) begin
                    state_n = S_EN;
                end
            end
            S_EN: begin
                if (rsp_match) begin
                    state_n = S_FN;
                end
            end
            S_FN: begin
                state_n = S_IDLE;
            end
            default: begin
                state_n = S_IDLE;
            end
        endcase
    end

    // load payload, held for the whole transaction
    always_ff @(posedge clk) begin
        if (state == S_IDLE && load_kind != LD_NONE) begin
            addr_q <= base + offset;
            kind_q <= load_kind;
            mode_q <= ext_mode;
        end
        if (state == S_EN && rsp_match) begin
            data_q <= rd_rsp.data;
        end
    end

    always_comb begin
        rd_req.addr  = addr_q;
        rd_req.id    = txn_id_t'(`RVS_LSU_ID);
        rd_req.valid = (state == S_MEM);
    end

    assign res_valid = (state == S_FN);
    assign idle      = (state == S_IDLE) || (state == S_FN);

    load_format load_format_inst (
        .raw    (data_q),
        .lane   (addr_q[2:0]),
        .kind   (kind_q),
        .mode   (mode_q),
        .result (res_data)
    );

    csr_unit csr_unit_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .op       (op),
        .csr_addr (csr_addr),
        .src1     (src1),
        .src2     (src2),
        .csrs     (csrs)
    );

    // a raised request keeps its address until the memory takes it
    req_held_until_accept: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rd_req.valid && !ar_hs) |=> (rd_req.valid && $stable(rd_req.addr))
    ) else $error("read request dropped or changed before accept");

    single_res_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        res_valid |=> !res_valid
    ) else $error("res_valid held for two cycles");

endmodule

//--- data_rd_mem.sv
`timescale 1ns/1ps
`include "rvs_macros.svh"

module data_rd_mem import rvs_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  rd_req_t rd_req,
    output logic    ar_hs,
    output rd_rsp_t rd_rsp
);

    localparam int CNT_W = $clog2(`RVS_RD_LATENCY + 1);

    logic             busy;
    logic [CNT_W-1:0] cnt;
    addr_t            addr_q;
    txn_id_t          id_q;
    logic [31:0]      dw_idx;

    // accept only while nothing is pending
    assign ar_hs = rd_req.valid && !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (ar_hs) begin
            busy <= 1'b1;
            cnt  <= CNT_W'(`RVS_RD_LATENCY - 1);
        end else if (busy) begin
            if (cnt == '0) begin
                busy <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            addr_q <= rd_req.addr;
            id_q   <= rd_req.id;
        end
    end

    // doubleword index, low 32 bits are enough for the rule
    assign dw_idx = addr_q[34:3];

    always_comb begin
        rd_rsp.done = busy && (cnt == '0);
        rd_rsp.id   = id_q;
        rd_rsp.data = {dw_idx ^ `RVS_MEM_PATTERN, dw_idx * 32'h0101_0101};
    end

    done_after_accept: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_rsp.done |-> $past(ar_hs, `RVS_RD_LATENCY)
    ) else $error("response done without matching accept");

endmodule

//--- mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top import rvs_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  load_kind_t load_kind,
    input  ext_mode_t  ext_mode,
    input  xlen_t      base,
    input  xlen_t      offset,
    input  stage_op_t  op,
    input  csr_addr_t  csr_addr,
    input  xlen_t      src1,
    input  xlen_t      src2,
    output logic       res_valid,
    output xlen_t      res_data,
    output logic       idle,
    output csr_file_t  csrs
);

    rd_req_t rd_req;
    rd_rsp_t rd_rsp;
    logic    ar_hs;

    mem_stage mem_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_kind (load_kind),
        .ext_mode  (ext_mode),
        .base      (base),
        .offset    (offset),
        .op        (op),
        .csr_addr  (csr_addr),
        .src1      (src1),
        .src2      (src2),
        .rd_req    (rd_req),
        .ar_hs     (ar_hs),
        .rd_rsp    (rd_rsp),
        .res_valid (res_valid),
        .res_data  (res_data),
        .idle      (idle),
        .csrs      (csrs)
    );

    // fixed-latency data memory on the load bus
    data_rd_mem data_rd_mem_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .rd_req (rd_req),
        .ar_hs  (ar_hs),
        .rd_rsp (rd_rsp)
    );

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset released just after a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

//--- mem_subsys_checker.sv
`timescale 1ns/1ps
`include "rvs_macros.svh"

module mem_subsys_checker import rvs_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  int         phase,
    input  load_kind_t load_kind,
    input  ext_mode_t  ext_mode,
    input  xlen_t      base,
    input  xlen_t      offset,
    input  stage_op_t  op,
    input  csr_addr_t  csr_addr,
    input  xlen_t      src1,
    input  xlen_t      src2,
    input  logic       res_valid,
    input  xlen_t      res_data,
    input  logic       idle,
    input  csr_file_t  csrs,
    output int         errors,
    output int         checks,
    output int         n_loads,
    output int         n_results
);

    int        err_cnt = 0;
    int        chk_cnt = 0;
    int        load_cnt = 0;
    int        res_cnt = 0;
    bit        reset_seen = 0;
    bit        load_pending = 0;
    bit        csr_pending = 0;
    xlen_t     exp_data;
    addr_t     load_addr;
    csr_file_t model;

    assign errors    = err_cnt;
    assign checks    = chk_cnt;
    assign n_loads   = load_cnt;
    assign n_results = res_cnt;

    function automatic string phase_name(int p);
        case (p)
            0: return "reset";
            1: return "load_matrix";
            2: return "load_stray";
            3: return "csr_write";
            4: return "ecall";
            5: return "csr_in_flight";
            default: return "unknown";
        endcase
    endfunction

    // contents rule of the data memory, per doubleword index
    function automatic xlen_t mem_word(addr_t addr);
        addr_t idx;
        idx = addr >> 3;
        return {idx[31:0] ^ `RVS_MEM_PATTERN, idx[31:0] * 32'h0101_0101};
    endfunction

    // pick bytes starting at the lane, then extend
    function automatic xlen_t expect_load(xlen_t word, logic [2:0] lane, load_kind_t kind,
                                          ext_mode_t mode);
        int    nbytes;
        int    b;
        int    pos;
        xlen_t v;
        case (kind)
            LD_BYTE: nbytes = 1;
            LD_HALF: nbytes = 2;
            LD_WORD: nbytes = 4;
            default: nbytes = 8;
        endcase
        v = '0;
        for (b = 0; b < nbytes; b++) begin
            pos = int'(lane) + b;
            // bytes past the top of the word read as zero
            if (pos < 8) begin
                v = v | (((word >> (8 * pos)) & 64'hff) << (8 * b));
            end
        end
        if (mode == EXT_SIGN_W) begin
            v = {{32{v[31]}}, v[31:0]};
        end else if (mode == EXT_ZERO_W) begin
            v[63:32] = '0;
        end else if (mode == EXT_SIGN_H) begin
            v = {{48{v[15]}}, v[15:0]};
        end
        return v;
    endfunction

    function automatic csr_file_t csr_next(csr_file_t cur, stage_op_t o, csr_addr_t a,
                                           xlen_t s1, xlen_t s2);
        csr_file_t n;
        xlen_t     val;
        n = cur;
        val = (o == OP_CSRRS) ? (s1 | s2) : s1;
        if (o == OP_ECALL) begin
            n.mepc = s1;
            n.mcause = xlen_t'(`RVS_ECALL_CAUSE);
            n.mstatus[7] = cur.mstatus[3];
            n.mstatus[3] = 1'b0;
        end else if (o == OP_CSRRS || o == OP_CSRRW) begin
            if (a == `RVS_CSR_MEPC) n.mepc = val;
            else if (a == `RVS_CSR_MCAUSE) n.mcause = val;
            else if (a == `RVS_CSR_MTVEC) n.mtvec = val;
            else if (a == `RVS_CSR_MSTATUS) n.mstatus = val;
        end
        return n;
    endfunction

    task automatic compare_value(string what, xlen_t exp, xlen_t act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("error %s %s: expected %h actual %h", phase_name(phase), what, exp, act);
        end
    endtask

    task automatic compare_csrs();
        compare_value("mepc", model.mepc, csrs.mepc);
        compare_value("mcause", model.mcause, csrs.mcause);
        compare_value("mtvec", model.mtvec, csrs.mtvec);
        compare_value("mstatus", model.mstatus, csrs.mstatus);
    endtask

    // outputs settle after the rising edge, so look at the falling one
    always @(negedge clk) begin
        if (!rst_n) begin
            model = '0;
            load_pending = 0;
            csr_pending = 0;
        end else begin
            if (!reset_seen) begin
                reset_seen = 1;
                compare_value("res_valid", 64'd0, xlen_t'(res_valid));
                compare_value("idle", 64'd1, xlen_t'(idle));
                compare_csrs();
            end
            if (res_valid) begin
                res_cnt++;
                compare_value("idle", 64'd1, xlen_t'(idle));
                if (load_pending) begin
                    compare_value("res_data", exp_data, res_data);
                end else begin
                    err_cnt++;
                    $display("%s: result pulse with no load in flight", phase_name(phase));
                end
                load_pending = 0;
            end else if (load_pending) begin
                // stage busy from the edge after the load was taken
                compare_value("idle", 64'd0, xlen_t'(idle));
            end
            // S_IDLE is idle without a result pulse
            if (idle && !res_valid && load_kind != LD_NONE) begin
                if (load_pending) begin
                    err_cnt++;
                    $display("%s: load taken while another was in flight", phase_name(phase));
                end
                load_addr = base + offset;
                exp_data = expect_load(mem_word(load_addr), load_addr[2:0], load_kind, ext_mode);
                load_pending = 1;
                load_cnt++;
            end
            if (csr_pending) begin
                compare_csrs();
                csr_pending = 0;
            end
            if (op != OP_NONE) begin
                model = csr_next(model, op, csr_addr, src1, src2);
                csr_pending = 1;
            end
        end
    end

endmodule

//--- mem_subsys_tb.sv
`timescale 1ns/1ps
`include "rvs_macros.svh"

module mem_subsys_tb import rvs_pkg::*; ();

    localparam int WAIT_LIMIT = 50;
    localparam int PH_RESET = 0;
    localparam int PH_LOAD = 1;
    localparam int PH_STRAY = 2;
    localparam int PH_CSR = 3;
    localparam int PH_ECALL = 4;
    localparam int PH_FLIGHT = 5;

    logic       clk;
    logic       rst_n;
    load_kind_t load_kind;
    ext_mode_t  ext_mode;
    xlen_t      base;
    xlen_t      offset;
    stage_op_t  op;
    csr_addr_t  csr_addr;
    xlen_t      src1;
    xlen_t      src2;
    logic       res_valid;
    xlen_t      res_data;
    logic       idle;
    csr_file_t  csrs;
    int         phase;
    int         tb_errors = 0;
    int         loads_issued = 0;
    int         errors;
    int         checks;
    int         n_loads;
    int         n_results;

    load_kind_t kind_list [4] = '{LD_BYTE, LD_HALF, LD_WORD, LD_DWORD};
    ext_mode_t  mode_list [4] = '{EXT_RAW, EXT_SIGN_W, EXT_ZERO_W, EXT_SIGN_H};
    stage_op_t  op_list [3] = '{OP_CSRRS, OP_CSRRW, OP_ECALL};
    csr_addr_t  addr_list [5] = '{`RVS_CSR_MEPC, `RVS_CSR_MCAUSE, `RVS_CSR_MTVEC,
                                  `RVS_CSR_MSTATUS, 12'h7c0};

    tb_clk_gen tb_clk_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_subsys_top mem_subsys_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_kind (load_kind),
        .ext_mode  (ext_mode),
        .base      (base),
        .offset    (offset),
        .op        (op),
        .csr_addr  (csr_addr),
        .src1      (src1),
        .src2      (src2),
        .res_valid (res_valid),
        .res_data  (res_data),
        .idle      (idle),
        .csrs      (csrs)
    );

    mem_subsys_checker mem_subsys_checker_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .phase     (phase),
        .load_kind (load_kind),
        .ext_mode  (ext_mode),
        .base      (base),
        .offset    (offset),
        .op        (op),
        .csr_addr  (csr_addr),
        .src1      (src1),
        .src2      (src2),
        .res_valid (res_valid),
        .res_data  (res_data),
        .idle      (idle),
        .csrs      (csrs),
        .errors    (errors),
        .checks    (checks),
        .n_loads   (n_loads),
        .n_results (n_results)
    );

    function automatic xlen_t rand_word();
        return {$urandom, $urandom};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_load_ready();
        int n;
        n = 0;
        while (!(idle && !res_valid) && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!(idle && !res_valid)) begin
            tb_errors++;
            $display("timeout: the stage did not return to idle");
        end
    endtask

    task automatic drive_random_csr();
        op = op_list[$urandom_range(2, 0)];
        csr_addr = addr_list[$urandom_range(4, 0)];
        src1 = rand_word();
        src2 = rand_word();
    endtask

    // one load, optionally with stray loads or csr traffic while busy
    task automatic issue_load(load_kind_t kind, ext_mode_t mode, xlen_t b, xlen_t off,
                              bit stray, bit busy_csr);
        int n;
        wait_load_ready();
        load_kind = kind;
        ext_mode = mode;
        base = b;
        offset = off;
        loads_issued++;
        next_cycle();
        load_kind = LD_NONE;
        n = 0;
        while (!res_valid && n < WAIT_LIMIT) begin
            if (stray && !idle) begin
                load_kind = kind_list[$urandom_range(3, 0)];
                ext_mode = mode_list[$urandom_range(3, 0)];
                base = rand_word();
                offset = rand_word();
            end else begin
                load_kind = LD_NONE;
            end
            if (busy_csr) begin
                drive_random_csr();
            end else begin
                op = OP_NONE;
            end
            next_cycle();
            n++;
        end
        load_kind = LD_NONE;
        op = OP_NONE;
        if (!res_valid) begin
            tb_errors++;
            $display("timeout: no result pulse for a load");
        end else begin
            next_cycle();
        end
    endtask

    task automatic csr_op(stage_op_t o, csr_addr_t a, xlen_t s1, xlen_t s2);
        op = o;
        csr_addr = a;
        src1 = s1;
        src2 = s2;
        next_cycle();
        op = OP_NONE;
        next_cycle();
    endtask

    initial begin
        int    k;
        int    m;
        int    r;
        int    n;
        xlen_t b;
        xlen_t off;
        void'($urandom(32'h5e8));
        load_kind = LD_NONE;
        ext_mode = EXT_RAW;
        base = '0;
        offset = '0;
        op = OP_NONE;
        csr_addr = '0;
        src1 = '0;
        src2 = '0;
        phase = PH_RESET;

        n = 0;
        while (rst_n !== 1'b1 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            tb_errors++;
            $display("timeout: reset was never released");
        end
        #2;
        next_cycle();
        next_cycle();

        // every kind with every mode, first aligned then random lanes
        phase = PH_LOAD;
        for (k = 0; k < 4; k++) begin
            for (m = 0; m < 4; m++) begin
                for (r = 0; r < 3; r++) begin
                    b = rand_word();
                    off = xlen_t'($urandom_range(63, 0));
                    if (r == 0) begin
                        b[2:0] = 3'd0;
                        off[2:0] = 3'd0;
                    end
                    issue_load(kind_list[k], mode_list[m], b, off, 1'b0, 1'b0);
                end
            end
        end

        phase = PH_STRAY;
        for (r = 0; r < 16; r++) begin
            issue_load(kind_list[$urandom_range(3, 0)], mode_list[$urandom_range(3, 0)],
                       rand_word(), rand_word(), 1'b1, 1'b0);
        end

        phase = PH_CSR;
        for (k = 0; k < 5; k++) begin
            csr_op(OP_CSRRW, addr_list[k], rand_word(), rand_word());
            csr_op(OP_CSRRS, addr_list[k], rand_word(), rand_word());
        end

        // mstatus bit 3 set before the trap, then a second trap with it clear
        phase = PH_ECALL;
        csr_op(OP_CSRRW, `RVS_CSR_MSTATUS, rand_word() | 64'h8, '0);
        csr_op(OP_ECALL, '0, rand_word(), rand_word());
        csr_op(OP_ECALL, `RVS_CSR_MTVEC, rand_word(), '0);
        csr_op(OP_CSRRS, `RVS_CSR_MSTATUS, 64'h8, '0);
        csr_op(OP_ECALL, '0, rand_word(), '0);

        phase = PH_FLIGHT;
        for (r = 0; r < 16; r++) begin
            issue_load(kind_list[$urandom_range(3, 0)], mode_list[$urandom_range(3, 0)],
                       rand_word(), rand_word(), r[0], 1'b1);
        end
        next_cycle();
        next_cycle();

        if (n_results != loads_issued) begin
            tb_errors++;
            $display("error load_count: expected %0d actual %0d", loads_issued, n_results);
        end
        if (n_loads != loads_issued) begin
            tb_errors++;
            $display("error load_accept: expected %0d actual %0d", loads_issued, n_loads);
        end
        $display("checks %0d, checker errors %0d, tb errors %0d, loads %0d, results %0d",
                 checks, errors, tb_errors, loads_issued, n_results);
        if (errors == 0 && tb_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
rvs_pkg.sv
load_format.sv
csr_unit.sv
mem_stage.sv
data_rd_mem.sv
mem_subsys_top.sv
tb_clk_gen.sv
mem_subsys_checker.sv
mem_subsys_tb.sv

//--- Makefile
TOP := mem_subsys_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f vlog.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
